//--- design/cad_ctrl.sv
// CNN engine job controller
// Walks output positions, pooling windows and kernel rows and issues
// one tap per cycle; each result group starts only when the MAC is idle
`timescale 1ns/1ps

module cad_ctrl import cad_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  in_valid2,
  input  mode_e mode,
  input  logic  idle,
  tap_if.ctrl   tap
);

  logic [1:0] state;
  mode_e      mode_q;
  logic [3:0] orow;
  logic [3:0] ocol;
  logic       win_r;
  logic       win_c;
  krow_t      kcnt;
  logic       last_win;
  logic [3:0] out_max;

  // Transposed mode has a single window per group
  assign last_win = (mode_q == MODE_DECONV) || (win_r && win_c);
  assign out_max  = (mode_q == MODE_DECONV) ? 4'(DECONV_OUT - 1) : 4'(CONV_OUT / 2 - 1);

  // --------------------------------------------------
  // Tap generation
  // --------------------------------------------------
  always_comb
  begin
    tap.valid     = (state == ST_ISSUE);
    tap.first_row = (kcnt == 0);
    tap.last_row  = (kcnt == K_SIZE - 1);
    tap.first_win = (mode_q == MODE_DECONV) || (!win_r && !win_c);
    tap.last_win  = last_win;
    if (mode_q == MODE_DECONV)
    begin
      // Kernel rotated 180, image shifted into the padded frame
      tap.row  = coord_t'(orow + kcnt - PAD);
      tap.col  = coord_t'(ocol - PAD);
      tap.krow = krow_t'(K_SIZE - 1 - kcnt);
      tap.flip = 1'b1;
    end
    else
    begin
      tap.row  = coord_t'(2 * orow + win_r + kcnt);
      tap.col  = coord_t'(2 * ocol + win_c);
      tap.krow = kcnt;
      tap.flip = 1'b0;
    end
  end

  // --------------------------------------------------
  // Job FSM and counters
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state  <= ST_IDLE;
      mode_q <= MODE_CONV_POOL;
      orow   <= '0;
      ocol   <= '0;
      win_r  <= 1'b0;
      win_c  <= 1'b0;
      kcnt   <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (in_valid2)
          begin
            mode_q <= mode;
            orow   <= '0;
            ocol   <= '0;
            win_r  <= 1'b0;
            win_c  <= 1'b0;
            kcnt   <= '0;
            state  <= ST_WAIT;
          end
        end
        ST_WAIT:
        begin
          if (idle)
            state <= ST_ISSUE;
        end
        ST_ISSUE:
        begin
          if (kcnt == K_SIZE - 1)
          begin
            kcnt <= '0;
            if (!last_win)
            begin
              // Window order (0,0) (0,1) (1,0) (1,1)
              win_c <= !win_c;
              if (win_c)
                win_r <= 1'b1;
            end
            else
            begin
              win_r <= 1'b0;
              win_c <= 1'b0;
              state <= ST_WAIT;
              if (ocol == out_max)
              begin
                ocol <= '0;
                if (orow == out_max)
                begin
                  orow  <= '0;
                  state <= ST_IDLE;
                end
                else
                  orow <= orow + 1'b1;
              end
              else
                ocol <= ocol + 1'b1;
            end
          end
          else
            kcnt <= kcnt + 1'b1;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- design/cad_if.sv
// CNN engine internal links
// tap_if carries fetch requests from the job FSM to the store,
// operand_if carries fetched rows from the store to the MAC
`timescale 1ns/1ps

interface tap_if import cad_pkg::*; ();
  logic   valid;
  coord_t row;
  coord_t col;
  krow_t  krow;
  logic   flip;
  logic   first_row;
  logic   last_row;
  logic   first_win;
  logic   last_win;

  modport ctrl (output valid, row, col, krow, flip, first_row, last_row, first_win, last_win);
  modport store (input valid, row, col, krow, flip, first_row, last_row, first_win, last_win);
endinterface

interface operand_if import cad_pkg::*; ();
  logic     valid;
  pix_vec_t img;
  pix_vec_t ker;
  logic     first_row;
  logic     last_row;
  logic     first_win;
  logic     last_win;

  modport store (output valid, img, ker, first_row, last_row, first_win, last_win);
  modport mac (input valid, img, ker, first_row, last_row, first_win, last_win);
endinterface

//--- design/cad_mac.sv
// CNN engine multiply-accumulate stage
// Five products per tap, row accumulation into a convolution sum,
// running max over a pooling group and req/ack result hand-off
`timescale 1ns/1ps

module cad_mac import cad_pkg::*; (
  input  logic    clk,
  input  logic    rst_n,
  operand_if.mac  opnd,
  output logic    idle,
  output logic    req,
  input  logic    ack,
  output acc_t    result
);

  acc_t prod [K_SIZE];
  acc_t prod_sum;
  acc_t prod_q;
  logic prod_vld;
  logic first_row_q;
  logic last_row_q;
  logic first_win_q;
  logic last_win_q;
  acc_t acc_q;
  acc_t sum_now;
  acc_t max_q;
  acc_t max_now;
  logic busy;
  logic ack_wait;

  always_comb
  begin
    prod_sum = '0;
    for (int j = 0; j < K_SIZE; j++)
    begin
      prod[j]  = pix_t'(opnd.img[j]) * pix_t'(opnd.ker[j]);
      prod_sum = prod_sum + prod[j];
    end
  end

  // Sum closes on the last_row product
  assign sum_now = first_row_q ? prod_q : acc_q + prod_q;
  assign max_now = (first_win_q || sum_now > max_q) ? sum_now : max_q;

  assign idle = !(busy || opnd.valid);

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      prod_vld    <= 1'b0;
      first_row_q <= 1'b0;
      last_row_q  <= 1'b0;
      first_win_q <= 1'b0;
      last_win_q  <= 1'b0;
    end
    else
    begin
      prod_vld    <= opnd.valid;
      first_row_q <= opnd.first_row;
      last_row_q  <= opnd.last_row;
      first_win_q <= opnd.first_win;
      last_win_q  <= opnd.last_win;
    end
  end

  always_ff @(posedge clk)
  begin
    if (opnd.valid)
      prod_q <= prod_sum;
    if (prod_vld)
      acc_q <= sum_now;
    if (prod_vld && last_row_q)
      max_q <= max_now;
    if (prod_vld && last_row_q && last_win_q)
      result <= max_now;
  end

  // --------------------------------------------------
  // Four-phase hand-off
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy     <= 1'b0;
      req      <= 1'b0;
      ack_wait <= 1'b0;
    end
    else
    begin
      if (opnd.valid)
        busy <= 1'b1;
      if (prod_vld && last_row_q && last_win_q)
        req <= 1'b1;
      else if (req && ack)
      begin
        req      <= 1'b0;
        ack_wait <= 1'b1;
      end
      else if (ack_wait && !ack)
      begin
        ack_wait <= 1'b0;
        busy     <= 1'b0;
      end
    end
  end

endmodule

//--- design/cad_pkg.sv
// CNN engine shared definitions
// Array sizes, data widths, element types and job mode encoding
package cad_pkg;

  // --------------------------------------------------
  // Sizes and widths
  // --------------------------------------------------
  localparam int IMG_SIZE   = 8;
  localparam int K_SIZE     = 5;
  localparam int PAD        = 4;
  localparam int CONV_OUT   = 4;
  localparam int DECONV_OUT = 12;
  localparam int PIX_W      = 8;
  localparam int ACC_W      = 20;

  // Image bytes first, kernel bytes after
  localparam int LOAD_LEN   = IMG_SIZE * IMG_SIZE + K_SIZE * K_SIZE;

  // Job FSM state codes
  localparam logic [1:0] ST_IDLE  = 2'd0;
  localparam logic [1:0] ST_WAIT  = 2'd1;
  localparam logic [1:0] ST_ISSUE = 2'd2;

  // --------------------------------------------------
  // Types
  // --------------------------------------------------
  typedef logic signed [PIX_W-1:0] pix_t;
  typedef logic signed [ACC_W-1:0] acc_t;

  // Covers -4 .. 11 in the padded frame
  typedef logic signed [4:0] coord_t;
  typedef logic [2:0] krow_t;

  // Five elements of one image or kernel row
  typedef pix_t [K_SIZE-1:0] pix_vec_t;

  typedef enum logic {
    MODE_CONV_POOL = 1'b0,
    MODE_DECONV    = 1'b1
  } mode_e;

endpackage

//--- design/cad_serializer.sv
// CNN engine output serializer
// Takes one result per handshake and sends it LSB first, one bit per cycle
`timescale 1ns/1ps

module cad_serializer import cad_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  output logic ack,
  input  acc_t result,
  output logic out_valid,
  output logic out_value
);

  logic       busy;
  logic [4:0] bit_cnt;
  acc_t       shift_q;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ack       <= 1'b0;
      busy      <= 1'b0;
      bit_cnt   <= '0;
      out_valid <= 1'b0;
      out_value <= 1'b0;
    end
    else
    begin
      // Capture only between runs
      if (!busy && req && !ack)
      begin
        ack     <= 1'b1;
        busy    <= 1'b1;
        bit_cnt <= '0;
      end
      else if (ack && !req)
        ack <= 1'b0;

      out_valid <= busy;
      out_value <= busy ? shift_q[0] : 1'b0;
      if (busy)
      begin
        bit_cnt <= bit_cnt + 1'b1;
        if (bit_cnt == ACC_W - 1)
          busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (!busy && req && !ack)
      shift_q <= result;
    else if (busy)
      shift_q <= shift_q >> 1;
  end

endmodule

//--- design/cad_store.sv
// CNN engine data store
// Holds the loaded image and kernel and fetches one padded image row
// segment and one kernel row per tap
`timescale 1ns/1ps

module cad_store import cad_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       in_valid,
  input  pix_t       matrix,
  tap_if.store       tap,
  operand_if.store   opnd
);

  pix_t              img_mem [IMG_SIZE][IMG_SIZE];
  pix_t              ker_mem [K_SIZE*K_SIZE];
  logic [6:0]        ld_cnt;
  logic              row_ok;
  logic signed [5:0] col_j [K_SIZE];
  logic [K_SIZE-1:0] col_ok;
  pix_vec_t          img_row;
  pix_vec_t          ker_row;

  // --------------------------------------------------
  // Load path
  // --------------------------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ld_cnt <= '0;
    else if (!in_valid)
      ld_cnt <= '0;
    else if (ld_cnt < LOAD_LEN)
      ld_cnt <= ld_cnt + 1'b1;
  end

  // Row-major image, then row-major kernel
  always_ff @(posedge clk)
  begin
    if (in_valid && ld_cnt < IMG_SIZE * IMG_SIZE)
      img_mem[ld_cnt[5:3]][ld_cnt[2:0]] <= matrix;
    else if (in_valid && ld_cnt < LOAD_LEN)
      ker_mem[5'(ld_cnt - IMG_SIZE * IMG_SIZE)] <= matrix;
  end

  // --------------------------------------------------
  // Windowed fetch
  // --------------------------------------------------
  always_comb
  begin
    row_ok = (tap.row >= 0) && (tap.row < IMG_SIZE);
    for (int j = 0; j < K_SIZE; j++)
    begin
      col_j[j]  = 6'(tap.col + j);
      col_ok[j] = (col_j[j] >= 0) && (col_j[j] < IMG_SIZE);
      // Zero outside the 8x8 image
      img_row[j] = (row_ok && col_ok[j]) ? img_mem[tap.row[2:0]][col_j[j][2:0]] : '0;
      ker_row[j] = tap.flip ? ker_mem[tap.krow * K_SIZE + K_SIZE - 1 - j]
                            : ker_mem[tap.krow * K_SIZE + j];
    end
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      opnd.valid     <= 1'b0;
      opnd.first_row <= 1'b0;
      opnd.last_row  <= 1'b0;
      opnd.first_win <= 1'b0;
      opnd.last_win  <= 1'b0;
    end
    else
    begin
      opnd.valid     <= tap.valid;
      opnd.first_row <= tap.first_row;
      opnd.last_row  <= tap.last_row;
      opnd.first_win <= tap.first_win;
      opnd.last_win  <= tap.last_win;
    end
  end

  always_ff @(posedge clk)
  begin
    if (tap.valid)
    begin
      opnd.img <= img_row;
      opnd.ker <= ker_row;
    end
  end

endmodule

//--- design/cad_top.sv
// CNN engine top level
// Loads an 8x8 image and 5x5 kernel, runs conv with max pooling or
// transposed conv, and streams 20-bit results bit-serially
`timescale 1ns/1ps

module cad_top import cad_pkg::*; (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             in_valid,
  input  logic [PIX_W-1:0] matrix,
  input  logic             in_valid2,
  input  logic             mode,
  output logic             out_valid,
  output logic             out_value
);

  logic idle;
  logic req;
  logic ack;
  acc_t result;

  tap_if     tap ();
  operand_if opnd ();

  cad_ctrl u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid2 (in_valid2),
    .mode      (mode_e'(mode)),
    .idle      (idle),
    .tap       (tap.ctrl)
  );

  cad_store u_store (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (in_valid),
    .matrix   (pix_t'(matrix)),
    .tap      (tap.store),
    .opnd     (opnd.store)
  );

  cad_mac u_mac (
    .clk    (clk),
    .rst_n  (rst_n),
    .opnd   (opnd.mac),
    .idle   (idle),
    .req    (req),
    .ack    (ack),
    .result (result)
  );

  cad_serializer u_ser (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (req),
    .ack       (ack),
    .result    (result),
    .out_valid (out_valid),
    .out_value (out_value)
  );

endmodule

//--- tb/cad_checker.sv
// CNN engine output checker
// Rebuilds 20-bit results from the serial output and compares them
// with the queue of expected values
`timescale 1ns/1ps

module cad_checker import cad_pkg::*; (
  input  logic clk,
  input  logic rst_n,
  input  logic out_valid,
  input  logic out_value,
  output int   done_cnt,
  output int   mismatch_cnt,
  output int   framing_cnt
);

  int         exp_q [$];
  logic [ACC_W-1:0] shift_q;
  int         run_len;

  initial
  begin
    done_cnt     = 0;
    mismatch_cnt = 0;
    framing_cnt  = 0;
    run_len      = 0;
    shift_q      = '0;
  end

  task automatic add_expected(input int value);
    exp_q.push_back(value);
  endtask

  function automatic int pending();
    return exp_q.size();
  endfunction

  task automatic compare_result(input acc_t got);
    int expected;
    if (exp_q.size() == 0)
    begin
      mismatch_cnt++;
      $display("** Error at %0t: result %0d arrived with none expected", $time, got);
    end
    else
    begin
      expected = exp_q.pop_front();
      if (int'(got) != expected)
      begin
        mismatch_cnt++;
        $display("** Error at %0t: result %0d expected %0d got %0d",
                 $time, done_cnt, expected, int'(got));
      end
    end
    done_cnt++;
  endtask

  // --------------------------------------------------
  // Serial capture, LSB first
  // --------------------------------------------------
  always @(posedge clk)
  begin
    if (!rst_n)
      run_len = 0;
    else if (out_valid)
    begin
      shift_q = {out_value, shift_q[ACC_W-1:1]};
      run_len++;
    end
    else if (run_len != 0)
    begin
      if (run_len != ACC_W)
      begin
        framing_cnt++;
        $display("Output run at %0t lasted %0d cycles instead of %0d", $time, run_len, ACC_W);
        // Keep the queue aligned with the runs
        if (exp_q.size() != 0)
          void'(exp_q.pop_front());
        done_cnt++;
      end
      else
        compare_result(acc_t'(shift_q));
      run_len = 0;
    end
  end

endmodule

//--- tb/tb_cad.sv
// CNN engine testbench
// Loads image and kernel data, starts conv-pool and transposed-conv jobs
// and queues reference results for the checker
`timescale 1ns/1ps

module tb_cad import cad_pkg::*; ();

  localparam int JOB_TIMEOUT = 20000;
  localparam int RES_MAX     = DECONV_OUT * DECONV_OUT;

  logic             clk;
  logic             rst_n;
  logic             in_valid;
  logic [PIX_W-1:0] matrix;
  logic             in_valid2;
  logic             mode;
  logic             out_valid;
  logic             out_value;

  int  done_cnt;
  int  mismatch_cnt;
  int  framing_cnt;
  int  other_err;
  bit  aborted;

  logic signed [PIX_W-1:0] img [IMG_SIZE][IMG_SIZE];
  logic signed [PIX_W-1:0] ker [K_SIZE][K_SIZE];
  int  exp_res [RES_MAX];

  cad_top dut0 (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .matrix    (matrix),
    .in_valid2 (in_valid2),
    .mode      (mode),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  cad_checker chk0 (
    .clk          (clk),
    .rst_n        (rst_n),
    .out_valid    (out_valid),
    .out_value    (out_value),
    .done_cnt     (done_cnt),
    .mismatch_cnt (mismatch_cnt),
    .framing_cnt  (framing_cnt)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  function automatic int cad_expect(input logic signed [PIX_W-1:0] im [IMG_SIZE][IMG_SIZE],
                                    input logic signed [PIX_W-1:0] kr [K_SIZE][K_SIZE],
                                    input bit md,
                                    output int res [RES_MAX]);
    int conv [CONV_OUT][CONV_OUT];
    int r, c, i, j, a, b, ir, ic, sum, best, n;
    n = 0;
    if (md == 1'b0)
    begin
      for (r = 0; r < CONV_OUT; r++)
        for (c = 0; c < CONV_OUT; c++)
        begin
          sum = 0;
          for (i = 0; i < K_SIZE; i++)
            for (j = 0; j < K_SIZE; j++)
              sum += int'(im[r+i][c+j]) * int'(kr[i][j]);
          conv[r][c] = sum;
        end
      // 2x2 max pooling, row-major
      for (r = 0; r < CONV_OUT / 2; r++)
        for (c = 0; c < CONV_OUT / 2; c++)
        begin
          best = conv[2*r][2*c];
          for (a = 0; a < 2; a++)
            for (b = 0; b < 2; b++)
              if (conv[2*r+a][2*c+b] > best)
                best = conv[2*r+a][2*c+b];
          res[n] = best;
          n++;
        end
    end
    else
    begin
      // Full convolution over the padded frame with the rotated kernel
      for (r = 0; r < DECONV_OUT; r++)
        for (c = 0; c < DECONV_OUT; c++)
        begin
          sum = 0;
          for (i = 0; i < K_SIZE; i++)
            for (j = 0; j < K_SIZE; j++)
            begin
              ir = r + i - PAD;
              ic = c + j - PAD;
              if (ir >= 0 && ir < IMG_SIZE && ic >= 0 && ic < IMG_SIZE)
                sum += int'(im[ir][ic]) * int'(kr[K_SIZE-1-i][K_SIZE-1-j]);
            end
          res[n] = sum;
          n++;
        end
    end
    return n;
  endfunction

  // --------------------------------------------------
  // Stimulus tasks
  // --------------------------------------------------
  task automatic fill_random();
    for (int r = 0; r < IMG_SIZE; r++)
      for (int c = 0; c < IMG_SIZE; c++)
        img[r][c] = PIX_W'($urandom);
    for (int r = 0; r < K_SIZE; r++)
      for (int c = 0; c < K_SIZE; c++)
        ker[r][c] = PIX_W'($urandom);
  endtask

  task automatic fill_const(input logic signed [PIX_W-1:0] value);
    for (int r = 0; r < IMG_SIZE; r++)
      for (int c = 0; c < IMG_SIZE; c++)
        img[r][c] = value;
    for (int r = 0; r < K_SIZE; r++)
      for (int c = 0; c < K_SIZE; c++)
        ker[r][c] = value;
  endtask

  // Image row-major, then kernel row-major
  task automatic load_data();
    for (int k = 0; k < LOAD_LEN; k++)
    begin
      @(negedge clk);
      in_valid = 1'b1;
      if (k < IMG_SIZE * IMG_SIZE)
        matrix = img[k / IMG_SIZE][k % IMG_SIZE];
      else
        matrix = ker[(k - IMG_SIZE * IMG_SIZE) / K_SIZE][(k - IMG_SIZE * IMG_SIZE) % K_SIZE];
    end
    @(negedge clk);
    in_valid = 1'b0;
    matrix   = '0;
  endtask

  task automatic run_job(input bit md);
    int n;
    int base;
    int cycles;
    if (aborted)
      return;
    n = cad_expect(img, ker, md, exp_res);
    for (int k = 0; k < n; k++)
      chk0.add_expected(exp_res[k]);
    base = done_cnt;
    @(negedge clk);
    in_valid2 = 1'b1;
    mode      = md;
    @(negedge clk);
    in_valid2 = 1'b0;
    mode      = 1'b0;
    cycles    = 0;
    while (done_cnt < base + n && cycles < JOB_TIMEOUT)
    begin
      @(negedge clk);
      cycles++;
    end
    if (done_cnt < base + n)
    begin
      $display("Timeout in mode %0d job, only %0d of %0d results came out",
               md, done_cnt - base, n);
      other_err++;
      aborted = 1'b1;
    end
  endtask

  // All -128 data hits the largest positive sum
  task automatic check_saturation();
    int n;
    n = cad_expect(img, ker, 1'b0, exp_res);
    for (int k = 0; k < n; k++)
      if (exp_res[k] != 409600)
      begin
        other_err++;
        $display("** Error at %0t: pooled reference %0d is %0d", $time, k, exp_res[k]);
      end
    n = cad_expect(img, ker, 1'b1, exp_res);
    if (exp_res[0] != 16384 || exp_res[5 * DECONV_OUT + 5] != 409600)
    begin
      other_err++;
      $display("** Error at %0t: transposed corner %0d centre %0d", $time,
               exp_res[0], exp_res[5 * DECONV_OUT + 5]);
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial
  begin
    in_valid  = 1'b0;
    matrix    = '0;
    in_valid2 = 1'b0;
    mode      = 1'b0;
    rst_n     = 1'b0;
    other_err = 0;
    aborted   = 1'b0;
    void'($urandom(32'hff2d_fb21));
    repeat (16) @(negedge clk);
    rst_n = 1'b1;

    // Output must stay quiet before any job
    for (int k = 0; k < 20; k++)
    begin
      @(negedge clk);
      if (out_valid)
      begin
        other_err++;
        $display("** Error at %0t: out_valid high before the first job", $time);
      end
    end

    fill_random();
    load_data();
    run_job(1'b0);

    fill_random();
    load_data();
    run_job(1'b0);
    run_job(1'b1);
    // Same data, no reload
    run_job(1'b1);
    run_job(1'b0);

    fill_const(-8'sd128);
    check_saturation();
    load_data();
    run_job(1'b0);
    run_job(1'b1);

    repeat (40) @(negedge clk);
    if (chk0.pending() != 0)
    begin
      other_err++;
      $display("%0d expected results never came out", chk0.pending());
    end

    $display("Errors: %0d mismatch, %0d framing, %0d other",
             mismatch_cnt, framing_cnt, other_err);
    if (mismatch_cnt + framing_cnt + other_err == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- vlog.f
design/cad_pkg.sv
design/cad_if.sv
design/cad_ctrl.sv
design/cad_store.sv
design/cad_mac.sv
design/cad_serializer.sv
design/cad_top.sv
tb/cad_checker.sv
tb/tb_cad.sv
